/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_rv_core
FILELIST = files.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, check the log"
	@echo "  clean  remove build output and log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* ex.sv */
`timescale 1ns/1ns
`default_nettype none

module ex (
    input  wire                    clk_i,
    input  wire                    rst_n_i,
    input  wire rv_core_pkg::dec_t dec_i,
    output rv_core_pkg::wb_t       wb_o,
    output rv_core_pkg::redirect_t redirect_o
);

    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    dec_t    dec_q;
    logic    valid_q;
    opcode_t opcode;
    func3_t  func3;
    logic    alt;
    xlen_t   imm_b;
    xlen_t   link;
    xlen_t   sra_res;
    xlen_t   jalr_sum;
    xlen_t   alu_res;
    logic    taken;
    addr_t   next_pc;
    xlen_t   wb_data;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= dec_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        dec_q <= dec_i;
    end

    assign opcode   = dec_q.inst[6:0];
    assign func3    = dec_q.inst[14:12];
    assign alt      = dec_q.inst[ALT_BIT];
    assign imm_b    = {{20{dec_q.inst[31]}}, dec_q.inst[7], dec_q.inst[30:25],
                       dec_q.inst[11:8], 1'b0};
    assign link     = dec_q.addr + PC_STEP;
    assign sra_res  = $signed(dec_q.op1) >>> dec_q.op2[4:0];
    assign jalr_sum = dec_q.op1 + dec_q.op2;

    always_comb begin
        alu_res = '0;
        case (func3)
            F3_ADD_SUB: begin
                if (opcode == OP_TYPE_R && alt) alu_res = dec_q.op1 - dec_q.op2;
                else alu_res = dec_q.op1 + dec_q.op2;  // addi has no sub
            end
            F3_SLL:  alu_res = dec_q.op1 << dec_q.op2[4:0];
            F3_SLT:  alu_res = {31'b0, $signed(dec_q.op1) < $signed(dec_q.op2)};
            F3_SLTU: alu_res = {31'b0, dec_q.op1 < dec_q.op2};
            F3_XOR:  alu_res = dec_q.op1 ^ dec_q.op2;
            F3_SR:   alu_res = alt ? sra_res : dec_q.op1 >> dec_q.op2[4:0];
            F3_OR:   alu_res = dec_q.op1 | dec_q.op2;
            F3_AND:  alu_res = dec_q.op1 & dec_q.op2;
            default: alu_res = '0;
        endcase
    end

    always_comb begin
        taken = 1'b0;
        case (func3)
            F3_BEQ:  taken = (dec_q.op1 == dec_q.op2);
            F3_BNE:  taken = (dec_q.op1 != dec_q.op2);
            F3_BLT:  taken = ($signed(dec_q.op1) < $signed(dec_q.op2));
            F3_BGE:  taken = ($signed(dec_q.op1) >= $signed(dec_q.op2));
            F3_BLTU: taken = (dec_q.op1 < dec_q.op2);
            F3_BGEU: taken = (dec_q.op1 >= dec_q.op2);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        wb_data = alu_res;
        next_pc = link;  // fall through
        case (opcode)
            OP_JAL: begin
                wb_data = link;
                next_pc = dec_q.addr + dec_q.op1;
            end
            OP_JALR: begin
                wb_data = link;
                next_pc = {jalr_sum[31:1], 1'b0};
            end
            OP_LUI: wb_data = dec_q.op1;
            OP_TYPE_B: begin
                if (taken) next_pc = dec_q.addr + imm_b;
            end
            default: wb_data = alu_res;
        endcase
    end

    assign wb_o       = '{valid: valid_q && dec_q.wen, rd: dec_q.rd, data: wb_data};
    assign redirect_o = '{valid: valid_q, addr: next_pc};

endmodule

`default_nettype wire

/* files.f */
rv_isa_pkg.sv
rv_core_pkg.sv
ifu.sv
id.sv
regs.sv
ex.sv
rv_core.sv
rv_core_properties.sv
tb_rv_core.sv

/* id.sv */
`timescale 1ns/1ns
`default_nettype none

module id (
    input  wire rv_core_pkg::fetch_t fetch_i,
    input  wire rv_isa_pkg::xlen_t   rs1_data_i,
    input  wire rv_isa_pkg::xlen_t   rs2_data_i,
    output rv_isa_pkg::reg_idx_t     rs1_addr_o,
    output rv_isa_pkg::reg_idx_t     rs2_addr_o,
    output rv_core_pkg::dec_t        dec_o
);

    import rv_isa_pkg::*;

    inst_t    inst;
    opcode_t  opcode;
    func3_t   func3;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    xlen_t    imm_i;
    xlen_t    imm_j;
    xlen_t    imm_u;
    xlen_t    shamt;

    assign inst   = fetch_i.inst;
    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign func3  = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};  // sign extended
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign shamt = {27'b0, inst[24:20]};

    always_comb begin
        rs1_addr_o  = '0;
        rs2_addr_o  = '0;
        dec_o.inst  = inst;
        dec_o.addr  = fetch_i.addr;
        dec_o.op1   = '0;
        dec_o.op2   = '0;
        dec_o.rd    = '0;
        dec_o.wen   = 1'b0;
        dec_o.valid = fetch_i.valid;  // bubbles still retire
        case (opcode)
            OP_TYPE_I: begin
                rs1_addr_o = rs1;
                dec_o.op1  = rs1_data_i;
                dec_o.rd   = rd;
                dec_o.wen  = 1'b1;
                case (func3)
                    F3_SLL, F3_SR: dec_o.op2 = shamt;
                    default:       dec_o.op2 = imm_i;
                endcase
            end
            OP_TYPE_R: begin
                rs1_addr_o = rs1;
                rs2_addr_o = rs2;
                dec_o.op1  = rs1_data_i;
                dec_o.op2  = rs2_data_i;
                dec_o.rd   = rd;
                dec_o.wen  = 1'b1;
            end
            OP_TYPE_B: begin
                case (func3)
                    F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU: begin
                        rs1_addr_o = rs1;
                        rs2_addr_o = rs2;
                        dec_o.op1  = rs1_data_i;
                        dec_o.op2  = rs2_data_i;
                    end
                    default: begin
                        dec_o.op1 = '0;  // bad func3, falls through
                    end
                endcase
            end
            OP_JAL: begin
                dec_o.op1 = imm_j;  // pc offset
                dec_o.rd  = rd;
                dec_o.wen = 1'b1;
            end
            OP_JALR: begin
                rs1_addr_o = rs1;
                dec_o.op1  = rs1_data_i;
                dec_o.op2  = imm_i;
                dec_o.rd   = rd;
                dec_o.wen  = 1'b1;
            end
            OP_LUI: begin
                dec_o.op1 = imm_u;
                dec_o.rd  = rd;
                dec_o.wen = 1'b1;
            end
            default: begin
                dec_o.wen = 1'b0;  // unknown opcode
            end
        endcase
    end

endmodule

`default_nettype wire

/* ifu.sv */
`timescale 1ns/1ns
`default_nettype none

module ifu (
    input  wire                         clk_i,
    input  wire                         rst_n_i,
    input  wire rv_core_pkg::redirect_t redirect_i,
    input  wire                         imem_ack_i,
    input  wire rv_isa_pkg::inst_t      imem_data_i,
    output logic                        imem_req_o,
    output rv_isa_pkg::addr_t           imem_addr_o,
    output rv_core_pkg::fetch_t         fetch_o
);

    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    fetch_state_e state_q;
    fetch_state_e state_d;
    addr_t        pc_q;
    inst_t        inst_q;
    logic         valid_q;
    logic         retired_q;  // retire came before ack dropped
    logic         capture;

    assign capture = (state_q == REQ) && imem_ack_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (!imem_ack_i) state_d = REQ;
            end
            REQ: begin
                if (imem_ack_i) state_d = WAIT_DROP;
            end
            WAIT_DROP: begin
                if (!imem_ack_i) begin
                    state_d = (retired_q || redirect_i.valid) ? REQ : HOLD;
                end
            end
            HOLD: begin
                if (redirect_i.valid) state_d = REQ;
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= IDLE;
            pc_q      <= RESET_PC;
            valid_q   <= 1'b0;
            retired_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            valid_q   <= capture;  // one cycle pulse
            retired_q <= (state_q == WAIT_DROP) && (retired_q || redirect_i.valid);
            if (redirect_i.valid) pc_q <= redirect_i.addr;
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) inst_q <= imem_data_i;
    end

    assign imem_req_o  = (state_q == REQ);
    assign imem_addr_o = pc_q;  // stable until next retire
    assign fetch_o     = '{inst: inst_q, addr: pc_q, valid: valid_q};

endmodule

`default_nettype wire

/* regs.sv */
`timescale 1ns/1ns
`default_nettype none

module regs (
    input  wire                       clk_i,
    input  wire                       rst_n_i,
    input  wire rv_isa_pkg::reg_idx_t rs1_addr_i,
    input  wire rv_isa_pkg::reg_idx_t rs2_addr_i,
    input  wire rv_core_pkg::wb_t     wb_i,
    output rv_isa_pkg::xlen_t         rs1_data_o,
    output rv_isa_pkg::xlen_t         rs2_data_o
);

    import rv_isa_pkg::*;

    xlen_t rf_q [NUM_REGS];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                rf_q[i] <= '0;
            end
        end else if (wb_i.valid && (wb_i.rd != '0)) begin
            rf_q[wb_i.rd] <= wb_i.data;  // x0 never written
        end
    end

    // x0 reads as zero
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : rf_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : rf_q[rs2_addr_i];

endmodule

`default_nettype wire

/* rv_core.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core (
    input  wire                    clk_i,
    input  wire                    rst_n_i,
    output logic                   imem_req_o,
    output rv_isa_pkg::addr_t      imem_addr_o,
    input  wire                    imem_ack_i,
    input  wire rv_isa_pkg::inst_t imem_data_i,
    output rv_core_pkg::wb_t       commit_o
);

    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    fetch_t    fetch;
    reg_idx_t  rs1_addr;
    reg_idx_t  rs2_addr;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    dec_t      dec;
    wb_t       wb;
    redirect_t redirect;

    ifu u_ifu (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .redirect_i  (redirect),
        .imem_ack_i  (imem_ack_i),
        .imem_data_i (imem_data_i),
        .imem_req_o  (imem_req_o),
        .imem_addr_o (imem_addr_o),
        .fetch_o     (fetch)
    );

    id u_id (
        .fetch_i    (fetch),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .dec_o      (dec)
    );

    regs u_regs (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .wb_i       (wb),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    ex u_ex (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .dec_i      (dec),
        .wb_o       (wb),
        .redirect_o (redirect)
    );

    assign commit_o = wb;  // retire write port

endmodule

`default_nettype wire

/* rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

    import rv_isa_pkg::*;

    typedef struct packed {
        inst_t inst;
        addr_t addr;
        logic  valid;
    } fetch_t;

    typedef struct packed {
        inst_t    inst;
        addr_t    addr;
        xlen_t    op1;
        xlen_t    op2;
        reg_idx_t rd;
        logic     wen;
        logic     valid;
    } dec_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        xlen_t    data;
    } wb_t;

    // retire plus next fetch address
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } redirect_t;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_DROP,
        HOLD
    } fetch_state_e;

endpackage

`default_nettype wire

/* rv_core_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core_properties (
    input wire                    clk_i,
    input wire                    rst_n_i,
    input wire                    imem_req_o,
    input wire rv_isa_pkg::addr_t imem_addr_o,
    input wire                    imem_ack_i,
    input wire rv_core_pkg::wb_t  commit_o
);

    import rv_isa_pkg::*;

    int fails = 0;  // failed assertion count

    // first cycle out of reset
    a_reset_state: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> !imem_req_o && imem_addr_o == RESET_PC)
        else begin
            fails++;
            $error("req or address wrong right after reset");
        end

    a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        imem_req_o && !imem_ack_i |=> imem_req_o && $stable(imem_addr_o))
        else begin
            fails++;
            $error("req dropped or address moved before ack");
        end

    a_req_fall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $fell(imem_req_o) |-> $past(imem_ack_i))
        else begin
            fails++;
            $error("req fell without ack");
        end

    a_req_rise: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(imem_req_o) |-> !imem_ack_i)
        else begin
            fails++;
            $error("req rose while ack still high");
        end

    // one retire per instruction
    a_commit_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        commit_o.valid |=> !commit_o.valid)
        else begin
            fails++;
            $error("commit valid held for two cycles");
        end

endmodule

bind rv_core rv_core_properties u_rv_core_properties (.*);

`default_nettype wire

/* rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [XLEN-1:0] addr_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [2:0]      func3_t;

    localparam addr_t RESET_PC = 32'h0000_0000;
    localparam addr_t PC_STEP  = 32'd4;          // one word per instruction

    localparam int ALT_BIT = 30;                 // func7 bit picking sub and sra

    // major opcodes
    localparam opcode_t OP_TYPE_I = 7'b0010011;
    localparam opcode_t OP_TYPE_R = 7'b0110011;
    localparam opcode_t OP_TYPE_B = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_LUI    = 7'b0110111;

    // alu func3, same for I and R forms
    localparam func3_t F3_ADD_SUB = 3'b000;
    localparam func3_t F3_SLL     = 3'b001;
    localparam func3_t F3_SLT     = 3'b010;
    localparam func3_t F3_SLTU    = 3'b011;
    localparam func3_t F3_XOR     = 3'b100;
    localparam func3_t F3_SR      = 3'b101;  // srl / sra
    localparam func3_t F3_OR      = 3'b110;
    localparam func3_t F3_AND     = 3'b111;

    // branch func3
    localparam func3_t F3_BEQ  = 3'b000;
    localparam func3_t F3_BNE  = 3'b001;
    localparam func3_t F3_BLT  = 3'b100;
    localparam func3_t F3_BGE  = 3'b101;
    localparam func3_t F3_BLTU = 3'b110;
    localparam func3_t F3_BGEU = 3'b111;

endpackage

`default_nettype wire

/* tb_rv_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core;

    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    logic     clk_i;
    logic     rst_n_i;
    logic     imem_ack_i;
    inst_t    imem_data_i;
    logic     imem_req_o;
    addr_t    imem_addr_o;
    wb_t      commit_o;
    inst_t    prog [128];
    xlen_t    mregs [32];
    int       n_inst;
    int       seed = 22;
    int       delay;
    int       cycles;
    int       limit;
    int       mism;
    int       errs;
    int       prop_fails;
    logic     req_q;
    logic     pend_wen;
    logic     done;
    reg_idx_t exp_rd;
    xlen_t    exp_data;
    addr_t    exp_pc;
    addr_t    halt_pc;

    rv_core u_rv_core (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .imem_req_o  (imem_req_o),
        .imem_addr_o (imem_addr_o),
        .imem_ack_i  (imem_ack_i),
        .imem_data_i (imem_data_i),
        .commit_o    (commit_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic inst_t enc_i(func3_t f, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f, rd[4:0], OP_TYPE_I};
    endfunction

    function automatic inst_t enc_r(int f7, int rs2, int rs1, func3_t f, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f, rd[4:0], OP_TYPE_R};
    endfunction

    function automatic inst_t enc_b(func3_t f, int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f, off[4:1], off[11], OP_TYPE_B};
    endfunction

    function automatic inst_t enc_j(int rd, int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OP_JAL};
    endfunction

    function automatic xlen_t alu(func3_t f3, logic is_r, logic alt, xlen_t x, xlen_t y);
        case (f3)
            F3_ADD_SUB: return (is_r && alt) ? x - y : x + y;
            F3_SLL:     return x << y[4:0];
            F3_SLT:     return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            F3_SLTU:    return (x < y) ? 32'd1 : 32'd0;
            F3_XOR:     return x ^ y;
            F3_SR:      return alt ? xlen_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
            F3_OR:      return x | y;
            default:    return x & y;
        endcase
    endfunction

    // ISA reference for one instruction, sets the expected commit and next pc
    task automatic model_step(inst_t i, addr_t pc);
        xlen_t a;
        xlen_t b;
        xlen_t imm_i;
        xlen_t res;
        logic  take;
        a        = mregs[i[19:15]];
        b        = mregs[i[24:20]];
        imm_i    = {{20{i[31]}}, i[31:20]};
        res      = '0;
        take     = 1'b0;
        pend_wen = 1'b0;
        exp_pc   = pc + 32'd4;
        case (i[6:0])
            OP_TYPE_I, OP_TYPE_R: begin
                pend_wen = 1'b1;
                res = alu(i[14:12], i[6:0] == OP_TYPE_R, i[30], a,
                          (i[6:0] == OP_TYPE_R) ? b : imm_i);
            end
            OP_LUI: begin
                pend_wen = 1'b1;
                res = {i[31:12], 12'b0};
            end
            OP_JAL: begin
                pend_wen = 1'b1;
                res = pc + 32'd4;
                exp_pc = pc + {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
            end
            OP_JALR: begin
                pend_wen = 1'b1;
                res = pc + 32'd4;
                exp_pc = (a + imm_i) & ~32'd1;
            end
            OP_TYPE_B: begin
                case (i[14:12])
                    F3_BEQ:  take = (a == b);
                    F3_BNE:  take = (a != b);
                    F3_BLT:  take = ($signed(a) < $signed(b));
                    F3_BGE:  take = ($signed(a) >= $signed(b));
                    F3_BLTU: take = (a < b);
                    F3_BGEU: take = (a >= b);
                    default: take = 1'b0;
                endcase
                if (take) exp_pc = pc + {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
            end
            default: pend_wen = 1'b0;  // bubble
        endcase
        exp_rd   = i[11:7];
        exp_data = res;
        if (pend_wen && exp_rd != 5'd0) mregs[exp_rd] = res;
    endtask

    task automatic put(inst_t i);
        prog[n_inst] = i;
        n_inst++;
    endtask

    always @(posedge clk_i) begin
        if (rst_n_i) begin
            cycles++;
            if (cycles > limit) begin
                $display("timeout: no halt fetch after %0d cycles", cycles);
                $display("TESTBENCH FAILED");
                $finish;
            end
        end
    end

    always @(posedge clk_i) begin
        if (rst_n_i) begin
            if (commit_o.valid) begin
                assert (pend_wen) else begin
                    errs++;
                    $display("commit seen with no write expected, rd %0d", commit_o.rd);
                end
                assert (commit_o.rd == exp_rd && commit_o.data == exp_data) else begin
                    mism++;
                    $display("MISMATCH commit: expected x%0d=%h actual x%0d=%h",
                             exp_rd, exp_data, commit_o.rd, commit_o.data);
                end
                pend_wen = 1'b0;
            end
            if (imem_req_o && !req_q) begin
                assert (imem_addr_o == exp_pc) else begin
                    mism++;
                    $display("MISMATCH fetch: expected %h actual %h", exp_pc, imem_addr_o);
                end
                assert (!pend_wen) else begin
                    errs++;
                    $display("expected register write never committed");
                end
            end
            if (imem_ack_i && !imem_req_o) begin
                imem_ack_i <= 1'b0;
            end else if (imem_req_o && !imem_ack_i) begin
                if (delay == 0) begin
                    imem_ack_i  <= 1'b1;
                    imem_data_i <= prog[imem_addr_o[8:2]];
                    model_step(prog[imem_addr_o[8:2]], imem_addr_o);
                    if (imem_addr_o == halt_pc) done = 1'b1;
                    delay = $random(seed) & 3;
                end else begin
                    delay--;
                end
            end
            req_q <= imem_req_o;
        end
    end

    initial begin
        func3_t bf [6];
        bf = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        rst_n_i = 1'b0;
        imem_ack_i = 1'b0;
        imem_data_i = '0;
        req_q = 1'b0;
        pend_wen = 1'b0;
        done = 1'b0;
        exp_pc = RESET_PC;
        exp_rd = '0;
        exp_data = '0;
        n_inst = 0;
        cycles = 0;
        mism = 0;
        errs = 0;
        prop_fails = 0;
        delay = $random(seed) & 3;
        for (int r = 0; r < 32; r++) mregs[r] = '0;
        for (int k = 0; k < 128; k++) prog[k] = enc_j(0, 0);
        put(enc_i(F3_ADD_SUB, 1, 0, 5));
        put(enc_i(F3_ADD_SUB, 2, 0, -3));
        for (int f = 0; f < 8; f++) begin
            put(enc_i(func3_t'(f), 3 + f, 2, (f == 1 || f == 5) ? 3 : -7));
            put(enc_r(0, 1, 2, func3_t'(f), 11 + f));
        end
        put(enc_i(F3_SR, 19, 2, 'h403));  // srai
        put(enc_r('h20, 1, 2, F3_ADD_SUB, 20));
        put(enc_r('h20, 1, 2, F3_SR, 21));
        put({20'h12345, 5'd22, OP_LUI});
        for (int f = 0; f < 6; f++) begin
            for (int p = 0; p < 3; p++) begin
                put(enc_b(bf[f], (p == 2) ? 2 : 1, (p == 1) ? 2 : 1, 8));
                put(enc_i(F3_ADD_SUB, 31, 31, 1));  // skipped when taken
            end
        end
        put(enc_j(23, 8));
        put(enc_i(F3_ADD_SUB, 31, 31, 1));
        put(enc_i(F3_ADD_SUB, 24, 0, n_inst * 4 + 5));  // odd base, jalr clears bit 0
        put({12'd8, 5'd24, 3'b000, 5'd25, OP_JALR});
        put(enc_i(F3_ADD_SUB, 31, 31, 1));
        put(enc_i(F3_ADD_SUB, 0, 1, 7));
        put(enc_r(0, 1, 0, F3_ADD_SUB, 26));
        put(32'h0000_007f);  // no such opcode
        put(enc_j(0, 0));
        halt_pc = addr_t'((n_inst - 1) * 4);
        limit = n_inst * 10 + 100;
        repeat (4) @(posedge clk_i);
        rst_n_i <= 1'b1;
        wait (done);
        repeat (8) @(posedge clk_i);
        prop_fails = u_rv_core.u_rv_core_properties.fails;
        $display("errors: %0d mismatches, %0d other failures, %0d property failures",
                 mism, errs, prop_fails);
        if (mism + errs + prop_fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
